/* Makefile */
SIM   := verilator
FLAGS := --binary --timing --assert -Wno-fatal -j 0
TOP   := tb_mrif
FLIST := all.f
OBJ   := obj_dir
LOG   := sim.log
PASS  := Done: no errors
FAIL  := Done: errors found

SRCS := $(filter-out +%,$(shell cat $(FLIST))) $(wildcard rtl/*.svh)
BIN  := $(OBJ)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ) -f $(FLIST)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL)" $(LOG) || ! grep -q "$(PASS)" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ) $(LOG)

/* all.f */
+incdir+rtl
rtl/mrif_pkg.sv
rtl/msi_credit_queue.sv
rtl/mrif_cfg_regs.sv
rtl/mrif_handler.sv
rtl/mrif_top.sv
test/tb_mrif_chk.sv
test/tb_mrif.sv

/* rtl/mrif_cfg_regs.sv */
`timescale 1ns/10ps
`include "mrif_defines.svh"

module mrif_cfg_regs import mrif_pkg::*; (
    input  logic        clk_i,
    input  logic        rst_ni,
    // Register write port
    input  logic        cfg_we_i,
    input  logic        cfg_addr_i,
    input  cfg_data_u   cfg_wdata_i,
    // Values seen by the handler
    output logic [46:0] mrif_addr_o,
    output logic [10:0] notice_nid_o,
    output logic [43:0] notice_ppn_o
);

    // Destination MRIF base, in 512-byte units
    logic [46:0] mrif_addr_q;
    // Notice MSI identity
    logic [10:0] notice_nid_q;
    // Notice MSI page number
    logic [43:0] notice_ppn_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            mrif_addr_q  <= '0;
            notice_nid_q <= '0;
            notice_ppn_q <= '0;
        end else if (cfg_we_i) begin
            // Offset selects the union view
            // Only the addressed register changes
            case (cfg_addr_i)
                `CFG_MRIF_ADDR: begin
                    mrif_addr_q <= cfg_wdata_i.mrif.addr;
                end
                `CFG_NOTICE: begin
                    notice_nid_q <= cfg_wdata_i.notice.nid;
                    notice_ppn_q <= cfg_wdata_i.notice.ppn;
                end
            endcase
        end
    end

    // Visible to the handler the cycle after the write
    assign mrif_addr_o  = mrif_addr_q;
    assign notice_nid_o = notice_nid_q;
    assign notice_ppn_o = notice_ppn_q;

endmodule

/* rtl/mrif_defines.svh */
`ifndef MRIF_DEFINES_SVH
`define MRIF_DEFINES_SVH

// MSI input queue entries
// Also the number of credits the sender starts with
`define MSI_QUEUE_DEPTH 4

// Physical address width on the memory bus
`define PADDR_W 56

// Fixed transaction IDs on the memory bus
// Reads fetch IP and IE, writes carry the IP update and the notice MSI
`define MRIF_RD_ID 4'h4
`define MRIF_WR_ID 4'h3

// Configuration register offsets
// Offset picks the view of the 64-bit write word
`define CFG_MRIF_ADDR 1'b0
`define CFG_NOTICE    1'b1

`endif

/* rtl/mrif_handler.sv */
`timescale 1ns/10ps
`include "mrif_defines.svh"

module mrif_handler import mrif_pkg::*; (
    input  logic         clk_i,
    input  logic         rst_ni,
    // Message from the queue
    input  logic         msi_valid_i,
    input  msi_req_t     msi_i,
    output logic         msi_ready_o,
    // Per-device configuration
    input  logic [46:0]  mrif_addr_i,
    input  logic [10:0]  notice_nid_i,
    input  logic [43:0]  notice_ppn_i,
    // Memory bus
    output mem_req_t     mem_req_o,
    input  mem_rsp_t     mem_rsp_i,
    // Completion
    output logic         status_valid_o,
    output mrif_status_t status_o
);

    typedef enum logic [2:0] {
        IDLE,
        READ_REQ,
        FETCH,
        WRITE_IP,
        WRITE_NOTICE,
        DRAIN,
        DONE
    } state_e;

    // Phases of one single-beat write
    typedef enum logic [1:0] {
        AW_REQ,
        W_DATA,
        B_RESP
    } wr_state_e;

    state_e       state_q, state_d;
    wr_state_e    wr_q, wr_d;
    mrif_status_t status_q, status_d;

    // Message payload, captured at take
    logic [`PADDR_W-1:0] pptr_q;
    logic [5:0]          bit_idx_q;
    logic [10:0]         nid_q;
    logic [43:0]         ppn_q;
    // IP with the new bit already set, and IE
    logic [63:0]         ip_q;
    logic [63:0]         ie_q;

    logic        take;
    logic        id_ok;
    logic        r_beat;
    logic [63:0] id_mask;

    // One message in flight, new take only from IDLE
    assign msi_ready_o = (state_q == IDLE);
    assign take        = msi_ready_o && msi_valid_i;
    // Identities above 2047 are dropped silently
    assign id_ok       = ~|msi_i.data[31:11];
    // r_ready is held high in FETCH, valid alone completes a beat
    assign r_beat      = (state_q == FETCH) && mem_rsp_i.r_valid;
    assign id_mask     = 64'd1 << bit_idx_q;

    assign status_valid_o = (state_q == DONE);
    assign status_o       = status_q;

    always_comb begin
        state_d  = state_q;
        wr_d     = wr_q;
        status_d = status_q;

        // Bus content fixed per state, only valids and readys switch
        mem_req_o         = '0;
        mem_req_o.ar_addr = pptr_q;
        mem_req_o.ar_id   = `MRIF_RD_ID;
        // Two beats, IP then IE
        mem_req_o.ar_len  = 8'd1;
        mem_req_o.aw_addr = pptr_q;
        mem_req_o.aw_id   = `MRIF_WR_ID;
        mem_req_o.aw_size = 3'b011;
        mem_req_o.w_data  = ip_q;
        mem_req_o.w_strb  = 8'hff;
        mem_req_o.w_last  = 1'b1;
        // Notice MSI, 32 bits at the start of the NPPN page
        if (state_q == WRITE_NOTICE) begin
            mem_req_o.aw_addr = {ppn_q, 12'b0};
            mem_req_o.aw_size = 3'b010;
            mem_req_o.w_data  = {53'b0, nid_q};
            mem_req_o.w_strb  = 8'h0f;
        end

        case (state_q)
            IDLE: begin
                if (take) begin
                    status_d = '0;
                    if (id_ok) begin
                        state_d = READ_REQ;
                    end else begin
                        status_d.aborted = 1'b1;
                        state_d          = DONE;
                    end
                end
            end
            READ_REQ: begin
                mem_req_o.ar_valid = 1'b1;
                if (mem_rsp_i.ar_ready) begin
                    state_d = FETCH;
                end
            end
            FETCH: begin
                mem_req_o.r_ready = 1'b1;
                if (mem_rsp_i.r_valid) begin
                    if (mem_rsp_i.r_resp != RESP_OKAY) begin
                        status_d.error = 1'b1;
                        status_d.cause = MSI_PT_DATA_CORRUPTION;
                        // Rest of the burst still has to be taken
                        state_d = mem_rsp_i.r_last ? DONE : DRAIN;
                    end else if (mem_rsp_i.r_last) begin
                        state_d = WRITE_IP;
                        wr_d    = AW_REQ;
                    end
                end
            end
            WRITE_IP, WRITE_NOTICE: begin
                case (wr_q)
                    AW_REQ: begin
                        mem_req_o.aw_valid = 1'b1;
                        if (mem_rsp_i.aw_ready) begin
                            wr_d = W_DATA;
                        end
                    end
                    W_DATA: begin
                        mem_req_o.w_valid = 1'b1;
                        if (mem_rsp_i.w_ready) begin
                            wr_d = B_RESP;
                        end
                    end
                    B_RESP: begin
                        mem_req_o.b_ready = 1'b1;
                        if (mem_rsp_i.b_valid) begin
                            wr_d = AW_REQ;
                            if (mem_rsp_i.b_resp != RESP_OKAY) begin
                                status_d.error = 1'b1;
                                status_d.cause = MSI_PT_DATA_CORRUPTION;
                                state_d        = DONE;
                            end else if (state_q == WRITE_IP && |(ie_q & id_mask)) begin
                                // Enabled interrupt, notify
                                state_d = WRITE_NOTICE;
                            end else begin
                                status_d.notice_sent = (state_q == WRITE_NOTICE);
                                state_d              = DONE;
                            end
                        end
                    end
                    default: begin
                        wr_d = AW_REQ;
                    end
                endcase
            end
            DRAIN: begin
                mem_req_o.r_ready = 1'b1;
                if (mem_rsp_i.r_valid && mem_rsp_i.r_last) begin
                    state_d = DONE;
                end
            end
            DONE: begin
                state_d = IDLE;
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q  <= IDLE;
            wr_q     <= AW_REQ;
            status_q <= '0;
        end else begin
            state_q  <= state_d;
            wr_q     <= wr_d;
            status_q <= status_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (take) begin
            // 16-byte IP/IE pair per 64 identities
            pptr_q    <= {mrif_addr_i, msi_i.data[10:6], 4'b0};
            bit_idx_q <= msi_i.data[5:0];
            nid_q     <= notice_nid_i;
            ppn_q     <= notice_ppn_i;
        end
        // First beat IP, set the pending bit on the way in
        if (r_beat && !mem_rsp_i.r_last) begin
            ip_q <= mem_rsp_i.r_data | id_mask;
        end
        if (r_beat && mem_rsp_i.r_last) begin
            ie_q <= mem_rsp_i.r_data;
        end
    end

endmodule

/* rtl/mrif_pkg.sv */
`include "mrif_defines.svh"

package mrif_pkg;

    // Incoming MSI, data word is the interrupt identity
    typedef struct packed {
        logic [31:0] data;
    } msi_req_t;

    // Fault causes reported with a completion
    typedef enum logic [11:0] {
        CAUSE_NONE             = 12'd0,
        MSI_PT_DATA_CORRUPTION = 12'd270
    } cause_e;

    // One completion per handled message
    typedef struct packed {
        logic   aborted;
        logic   error;
        logic   notice_sent;
        cause_e cause;
    } mrif_status_t;

    // MRIF base view of a configuration write
    typedef struct packed {
        logic [16:0] rsvd;
        logic [46:0] addr;
    } cfg_mrif_t;

    // Notice view, NID in the low bits and NPPN above it
    typedef struct packed {
        logic [8:0]  rsvd;
        logic [43:0] ppn;
        logic [10:0] nid;
    } cfg_notice_t;

    // Same 64-bit write word, decoded by register offset
    typedef union packed {
        cfg_mrif_t   mrif;
        cfg_notice_t notice;
    } cfg_data_u;

    // Bus response codes
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } resp_e;

    // Reduced memory bus, requester side
    typedef struct packed {
        // AR
        logic                ar_valid;
        logic [`PADDR_W-1:0] ar_addr;
        logic [3:0]          ar_id;
        logic [7:0]          ar_len;
        // AW
        logic                aw_valid;
        logic [`PADDR_W-1:0] aw_addr;
        logic [3:0]          aw_id;
        logic [2:0]          aw_size;
        // W
        logic                w_valid;
        logic [63:0]         w_data;
        logic [7:0]          w_strb;
        logic                w_last;
        // R and B
        logic                r_ready;
        logic                b_ready;
    } mem_req_t;

    // Reduced memory bus, responder side
    typedef struct packed {
        logic        ar_ready;
        logic        aw_ready;
        logic        w_ready;
        logic        r_valid;
        logic [63:0] r_data;
        resp_e       r_resp;
        logic        r_last;
        logic        b_valid;
        resp_e       b_resp;
    } mem_rsp_t;

endpackage

/* rtl/mrif_top.sv */
`timescale 1ns/10ps

module mrif_top import mrif_pkg::*; (
    input  logic         clk_i,
    input  logic         rst_ni,
    // Credit-based MSI input
    input  logic         msi_valid_i,
    input  msi_req_t     msi_i,
    output logic         credit_o,
    // Configuration writes
    input  logic         cfg_we_i,
    input  logic         cfg_addr_i,
    input  cfg_data_u    cfg_wdata_i,
    // Memory bus
    output mem_req_t     mem_req_o,
    input  mem_rsp_t     mem_rsp_i,
    // Completion
    output logic         status_valid_o,
    output mrif_status_t status_o
);

    // Queue to handler
    logic        q_valid;
    logic        q_ready;
    msi_req_t    q_msi;

    // Configuration to handler
    logic [46:0] mrif_addr;
    logic [10:0] notice_nid;
    logic [43:0] notice_ppn;

    msi_credit_queue queue_i (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .msi_valid_i (msi_valid_i),
        .msi_i       (msi_i),
        .credit_o    (credit_o),
        .pop_valid_o (q_valid),
        .pop_msi_o   (q_msi),
        .pop_ready_i (q_ready)
    );

    mrif_cfg_regs cfg_i (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .cfg_we_i     (cfg_we_i),
        .cfg_addr_i   (cfg_addr_i),
        .cfg_wdata_i  (cfg_wdata_i),
        .mrif_addr_o  (mrif_addr),
        .notice_nid_o (notice_nid),
        .notice_ppn_o (notice_ppn)
    );

    mrif_handler handler_i (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .msi_valid_i    (q_valid),
        .msi_i          (q_msi),
        .msi_ready_o    (q_ready),
        .mrif_addr_i    (mrif_addr),
        .notice_nid_i   (notice_nid),
        .notice_ppn_i   (notice_ppn),
        .mem_req_o      (mem_req_o),
        .mem_rsp_i      (mem_rsp_i),
        .status_valid_o (status_valid_o),
        .status_o       (status_o)
    );

endmodule

/* rtl/msi_credit_queue.sv */
`timescale 1ns/10ps
`include "mrif_defines.svh"

module msi_credit_queue import mrif_pkg::*; (
    input  logic     clk_i,
    input  logic     rst_ni,
    // Credit-gated push side
    input  logic     msi_valid_i,
    input  msi_req_t msi_i,
    output logic     credit_o,
    // Handler side
    output logic     pop_valid_o,
    output msi_req_t pop_msi_o,
    input  logic     pop_ready_i
);

    localparam int unsigned DEPTH = `MSI_QUEUE_DEPTH;
    localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int unsigned CNT_W = $clog2(DEPTH + 1);

    // Entry storage
    msi_req_t         mem_q [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    // Occupied entries
    logic [CNT_W-1:0] count_q;
    logic             pop;

    // Pointer step with wrap, depth need not be a power of two
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // Empty queue never presents an entry
    assign pop_valid_o = (count_q != '0);
    assign pop_msi_o   = mem_q[rd_ptr_q];
    assign pop         = pop_valid_o && pop_ready_i;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
            credit_o <= 1'b0;
        end else begin
            // Sender holds a credit, so a push always has room
            if (msi_valid_i) begin
                wr_ptr_q <= ptr_inc(wr_ptr_q);
            end
            if (pop) begin
                rd_ptr_q <= ptr_inc(rd_ptr_q);
            end
            case ({msi_valid_i, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
            // One credit back, the cycle after each take
            credit_o <= pop;
        end
    end

    always_ff @(posedge clk_i) begin
        if (msi_valid_i) begin
            mem_q[wr_ptr_q] <= msi_i;
        end
    end

endmodule

/* test/tb_mrif.sv */
`timescale 1ns/10ps
`include "mrif_defines.svh"

module tb_mrif import mrif_pkg::*; ();

    localparam int CLK_PERIOD   = 20;
    localparam int DRIVE_DLY    = 1;
    localparam int RESET_CYCLES = 3;
    // Watchdog budget, messages over all tests times a per-message bound
    localparam int N_MSGS       = 14;
    localparam int MSG_CYCLES   = 60;
    localparam int WAIT_CYCLES  = 200;
    localparam int BURST_LEN    = 8;

    localparam logic [46:0] BASE_A = 47'h1234;
    localparam logic [46:0] BASE_B = 47'h5678;
    localparam logic [10:0] NID    = 11'h2a5;
    localparam logic [43:0] NPPN   = 44'habc;

    logic         clk;
    logic         rst_n;
    logic         msi_valid;
    msi_req_t     msi;
    logic         credit;
    logic         cfg_we;
    logic         cfg_addr;
    cfg_data_u    cfg_wdata;
    mem_req_t     mem_req;
    mem_rsp_t     mem_rsp;
    logic         status_valid;
    mrif_status_t status;

    // Completions in arrival order
    mrif_status_t done_q [$];
    int           credits;
    int           n_bus;
    int           n_writes;
    // Size of the most recent write request
    logic [2:0]   last_aw_size;
    logic [31:0]  lfsr_state = 32'haf0c;
    // Sparse memory, doubleword aligned keys
    logic [63:0]  mem [logic [55:0]];
    // Addresses that answer SLVERR
    bit           bad_addr [logic [55:0]];

    mrif_top dut_i (
        .clk_i          (clk),
        .rst_ni         (rst_n),
        .msi_valid_i    (msi_valid),
        .msi_i          (msi),
        .credit_o       (credit),
        .cfg_we_i       (cfg_we),
        .cfg_addr_i     (cfg_addr),
        .cfg_wdata_i    (cfg_wdata),
        .mem_req_o      (mem_req),
        .mem_rsp_i      (mem_rsp),
        .status_valid_o (status_valid),
        .status_o       (status)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Mid-cycle sampling of completions and returned credits
    always @(negedge clk) begin
        if (rst_n && status_valid) begin
            done_q.push_back(status);
        end
        if (rst_n && credit) begin
            credits++;
        end
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Done: errors found");
        $fatal(1, "simulation stopped");
    endtask

    // Bound protocol assertions count their failures
    always @(negedge clk) begin
        if (dut_i.chk_i.fail_count != 0) begin
            fail_run("A bus or credit protocol assertion failed");
        end
    end

    task automatic check_eq(input string name, input logic [63:0] exp, input logic [63:0] act);
        if (act !== exp) begin
            fail_run($sformatf("MISMATCH %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #DRIVE_DLY;
        end
    endtask

    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] bits;
        int          i;
        bits = '0;
        for (i = 0; i < n; i++) begin
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003) : (lfsr_state >> 1);
            bits = {bits[30:0], lfsr_state[0]};
        end
        return bits;
    endfunction

    function automatic int rand_delay();
        logic [31:0] r;
        r = lfsr_bits(2);
        return int'(r[1:0]);
    endfunction

    function automatic logic [63:0] mem_peek(input logic [55:0] addr);
        // Untouched doublewords read a pattern of the full address
        if (mem.exists(addr)) begin
            return mem[addr];
        end
        return {8'ha5, addr};
    endfunction

    // IP doubleword of identity id, 16 bytes per 64 identities
    function automatic logic [55:0] ip_addr(input logic [46:0] base, input logic [31:0] id);
        return {base, 9'b0} + 56'((id / 64) * 16);
    endfunction

    function automatic mrif_status_t make_status(input logic aborted, input logic error,
                                                 input logic notice);
        mrif_status_t s;
        s             = '0;
        s.aborted     = aborted;
        s.error       = error;
        s.notice_sent = notice;
        s.cause       = error ? MSI_PT_DATA_CORRUPTION : CAUSE_NONE;
        return s;
    endfunction

    task automatic serve_read();
        logic [55:0] addr;
        int          beats;
        int          i;
        addr  = {mem_req.ar_addr[55:3], 3'b0};
        beats = int'(mem_req.ar_len) + 1;
        n_bus++;
        check_eq("bus ar_id", 64'(`MRIF_RD_ID), 64'(mem_req.ar_id));
        // IP and IE in one burst
        check_eq("bus ar_len", 64'd1, 64'(mem_req.ar_len));
        wait_cycles(rand_delay());
        mem_rsp.ar_ready = 1'b1;
        wait_cycles(1);
        mem_rsp.ar_ready = 1'b0;
        for (i = 0; i < beats; i++) begin
            wait_cycles(rand_delay());
            mem_rsp.r_valid = 1'b1;
            mem_rsp.r_data  = mem_peek(addr + 56'(i * 8));
            mem_rsp.r_resp  = bad_addr.exists(addr) ? RESP_SLVERR : RESP_OKAY;
            mem_rsp.r_last  = (i == beats - 1);
            while (!mem_req.r_ready) wait_cycles(1);
            wait_cycles(1);
            mem_rsp.r_valid = 1'b0;
            mem_rsp.r_last  = 1'b0;
        end
    endtask

    task automatic serve_write();
        logic [55:0] addr;
        logic [63:0] data;
        logic [7:0]  strb;
        logic [63:0] cur;
        int          b;
        addr         = {mem_req.aw_addr[55:3], 3'b0};
        last_aw_size = mem_req.aw_size;
        n_bus++;
        n_writes++;
        check_eq("bus aw_id", 64'(`MRIF_WR_ID), 64'(mem_req.aw_id));
        wait_cycles(rand_delay());
        mem_rsp.aw_ready = 1'b1;
        wait_cycles(1);
        mem_rsp.aw_ready = 1'b0;
        while (!mem_req.w_valid) wait_cycles(1);
        wait_cycles(rand_delay());
        data = mem_req.w_data;
        strb = mem_req.w_strb;
        // Single-beat write
        check_eq("bus w_last", 64'd1, 64'(mem_req.w_last));
        mem_rsp.w_ready = 1'b1;
        wait_cycles(1);
        mem_rsp.w_ready = 1'b0;
        // Failing address drops the data
        if (!bad_addr.exists(addr)) begin
            cur = mem_peek(addr);
            for (b = 0; b < 8; b++) begin
                if (strb[b]) cur[8*b +: 8] = data[8*b +: 8];
            end
            mem[addr] = cur;
        end
        wait_cycles(rand_delay());
        mem_rsp.b_valid = 1'b1;
        mem_rsp.b_resp  = bad_addr.exists(addr) ? RESP_SLVERR : RESP_OKAY;
        while (!mem_req.b_ready) wait_cycles(1);
        wait_cycles(1);
        mem_rsp.b_valid = 1'b0;
    endtask

    // Memory model, one transaction at a time
    initial begin
        mem_rsp = '0;
        forever begin
            wait_cycles(1);
            if (mem_req.ar_valid) begin
                serve_read();
            end else if (mem_req.aw_valid) begin
                serve_write();
            end
        end
    end

    initial begin
        #(CLK_PERIOD * (RESET_CYCLES + N_MSGS * MSG_CYCLES + 100));
        fail_run("Watchdog expired before the tests finished");
    end

    task automatic cfg_write(input logic sel, input cfg_data_u data);
        wait_cycles(1);
        cfg_we    = 1'b1;
        cfg_addr  = sel;
        cfg_wdata = data;
        wait_cycles(1);
        cfg_we    = 1'b0;
    endtask

    task automatic set_base(input logic [46:0] base);
        cfg_data_u w;
        w           = '0;
        w.mrif.addr = base;
        cfg_write(`CFG_MRIF_ADDR, w);
    endtask

    task automatic set_notice(input logic [10:0] nid, input logic [43:0] ppn);
        cfg_data_u w;
        w            = '0;
        w.notice.nid = nid;
        w.notice.ppn = ppn;
        cfg_write(`CFG_NOTICE, w);
    endtask

    // Push one MSI once a credit is held
    task automatic send_msi(input logic [31:0] id);
        int waited;
        waited = 0;
        while (credits == 0) begin
            wait_cycles(1);
            waited++;
            if (waited > WAIT_CYCLES) fail_run("No credit came back from the queue");
        end
        wait_cycles(1);
        msi_valid = 1'b1;
        msi.data  = id;
        credits--;
        wait_cycles(1);
        msi_valid = 1'b0;
    endtask

    task automatic wait_status(output mrif_status_t got);
        int waited;
        waited = 0;
        while (done_q.size() == 0) begin
            wait_cycles(1);
            waited++;
            if (waited > WAIT_CYCLES) fail_run("No completion status arrived in time");
        end
        got = done_q.pop_front();
    endtask

    task automatic test_ie_clear();
        logic [55:0]  a;
        logic [63:0]  old;
        mrif_status_t got;
        int           wr0;
        a        = ip_addr(BASE_A, 70);
        old      = 64'h0123_4567_0000_0001;
        mem[a]   = old;
        // Everything enabled except identity 70
        mem[a+8] = ~(64'd1 << (70 % 64));
        wr0      = n_writes;
        send_msi(32'd70);
        wait_status(got);
        check_eq("ie_clear status", make_status(1'b0, 1'b0, 1'b0), got);
        check_eq("ie_clear ip", old | (64'd1 << (70 % 64)), mem_peek(a));
        check_eq("ie_clear writes", 64'd1, 64'(n_writes - wr0));
        // Doubleword write-back
        check_eq("ie_clear size", 64'd3, 64'(last_aw_size));
    endtask

    task automatic test_ie_set();
        logic [55:0]  a;
        logic [55:0]  na;
        mrif_status_t got;
        int           wr0;
        a        = ip_addr(BASE_A, 200);
        na       = {NPPN, 12'b0};
        mem[a]   = 64'h00f0_0000_0000_0000;
        mem[a+8] = 64'd1 << (200 % 64);
        // Upper half must survive the 32-bit notice
        mem[na]  = 64'hffff_ffff_0000_0000;
        wr0      = n_writes;
        send_msi(32'd200);
        wait_status(got);
        check_eq("ie_set status", make_status(1'b0, 1'b0, 1'b1), got);
        check_eq("ie_set ip", 64'h00f0_0000_0000_0000 | (64'd1 << (200 % 64)), mem_peek(a));
        check_eq("ie_set notice", {32'hffff_ffff, 32'(NID)}, mem_peek(na));
        check_eq("ie_set writes", 64'd2, 64'(n_writes - wr0));
        check_eq("ie_set notice size", 64'd2, 64'(last_aw_size));
    endtask

    task automatic test_abort();
        mrif_status_t got;
        int           bus0;
        bus0 = n_bus;
        send_msi(32'd2048);
        wait_status(got);
        check_eq("abort status", make_status(1'b1, 1'b0, 1'b0), got);
        check_eq("abort bus", 64'd0, 64'(n_bus - bus0));
    endtask

    task automatic test_bus_error();
        logic [55:0]  a;
        logic [55:0]  na;
        mrif_status_t got;
        int           wr0;
        // SLVERR on the IP/IE read
        a           = ip_addr(BASE_A, 300);
        mem[a]      = 64'h0000_5555_0000_aaaa;
        bad_addr[a] = 1'b1;
        wr0         = n_writes;
        send_msi(32'd300);
        wait_status(got);
        check_eq("read_err status", make_status(1'b0, 1'b1, 1'b0), got);
        check_eq("read_err ip", 64'h0000_5555_0000_aaaa, mem_peek(a));
        check_eq("read_err writes", 64'd0, 64'(n_writes - wr0));
        bad_addr.delete(a);
        // SLVERR on the notice write response
        a            = ip_addr(BASE_A, 400);
        na           = {NPPN, 12'b0};
        mem[a]       = '0;
        mem[a+8]     = 64'd1 << (400 % 64);
        bad_addr[na] = 1'b1;
        wr0          = n_writes;
        send_msi(32'd400);
        wait_status(got);
        check_eq("notice_err status", make_status(1'b0, 1'b1, 1'b0), got);
        check_eq("notice_err ip", 64'd1 << (400 % 64), mem_peek(a));
        check_eq("notice_err writes", 64'd2, 64'(n_writes - wr0));
        bad_addr.delete(na);
    endtask

    task automatic test_burst();
        logic [31:0]  ids [BURST_LEN];
        mrif_status_t exp [BURST_LEN];
        mrif_status_t got;
        logic [63:0]  ie;
        int           i;
        int           waited;
        // 12-bit identities, about half of them out of range
        for (i = 0; i < BURST_LEN; i++) begin
            ids[i] = lfsr_bits(12);
            ie     = mem_peek(ip_addr(BASE_A, ids[i]) + 56'd8);
            if (ids[i] >= 2048) begin
                exp[i] = make_status(1'b1, 1'b0, 1'b0);
            end else begin
                exp[i] = make_status(1'b0, 1'b0, ie[ids[i][5:0]]);
            end
        end
        for (i = 0; i < BURST_LEN; i++) begin
            send_msi(ids[i]);
        end
        for (i = 0; i < BURST_LEN; i++) begin
            wait_status(got);
            check_eq($sformatf("burst status %0d", i), exp[i], got);
        end
        waited = 0;
        while (credits != `MSI_QUEUE_DEPTH && waited < WAIT_CYCLES) begin
            wait_cycles(1);
            waited++;
        end
        check_eq("burst credits", 64'(`MSI_QUEUE_DEPTH), 64'(credits));
    endtask

    task automatic test_rebase();
        logic [55:0]  a_old;
        logic [55:0]  a_new;
        logic [63:0]  old_val;
        mrif_status_t got;
        a_old        = ip_addr(BASE_A, 70);
        a_new        = ip_addr(BASE_B, 70);
        old_val      = mem_peek(a_old);
        mem[a_new]   = '0;
        mem[a_new+8] = '0;
        set_base(BASE_B);
        send_msi(32'd70);
        wait_status(got);
        check_eq("rebase status", make_status(1'b0, 1'b0, 1'b0), got);
        check_eq("rebase new ip", 64'd1 << (70 % 64), mem_peek(a_new));
        check_eq("rebase old ip", old_val, mem_peek(a_old));
    endtask

    initial begin
        rst_n        = 1'b0;
        msi_valid    = 1'b0;
        msi          = '0;
        cfg_we       = 1'b0;
        cfg_addr     = 1'b0;
        cfg_wdata    = '0;
        credits      = `MSI_QUEUE_DEPTH;
        n_bus        = 0;
        n_writes     = 0;
        last_aw_size = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DLY;
        rst_n = 1'b1;
        set_base(BASE_A);
        set_notice(NID, NPPN);
        test_ie_clear();
        test_ie_set();
        test_abort();
        test_bus_error();
        test_burst();
        test_rebase();
        if (dut_i.chk_i.fail_count != 0) begin
            fail_run("A bus or credit protocol assertion failed");
        end else begin
            $display("Done: no errors");
            $finish;
        end
    end

endmodule

/* test/tb_mrif_chk.sv */
`timescale 1ns/10ps
`include "mrif_defines.svh"

module tb_mrif_chk import mrif_pkg::*; (
    input logic     clk_i,
    input logic     rst_ni,
    input logic     msi_valid_i,
    input logic     credit_o,
    input mem_req_t mem_req_o,
    input mem_rsp_t mem_rsp_i,
    input logic     status_valid_o
);

    // Sender credits, rebuilt from pushes and returned credits
    int credits;
    // Failed assertions so far
    int fail_count = 0;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            credits <= `MSI_QUEUE_DEPTH;
        end else begin
            credits <= credits - int'(msi_valid_i) + int'(credit_o);
        end
    end

    // Request channels hold valid and content until ready
    ar_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
        mem_req_o.ar_valid && !mem_rsp_i.ar_ready |=> mem_req_o.ar_valid
        && $stable(mem_req_o.ar_addr) && $stable(mem_req_o.ar_len))
        else begin
            $error("AR request changed before its handshake");
            fail_count++;
        end

    aw_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
        mem_req_o.aw_valid && !mem_rsp_i.aw_ready |=> mem_req_o.aw_valid
        && $stable(mem_req_o.aw_addr) && $stable(mem_req_o.aw_size))
        else begin
            $error("AW request changed before its handshake");
            fail_count++;
        end

    w_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
        mem_req_o.w_valid && !mem_rsp_i.w_ready |=> mem_req_o.w_valid
        && $stable(mem_req_o.w_data) && $stable(mem_req_o.w_strb))
        else begin
            $error("W beat changed before its handshake");
            fail_count++;
        end

    // Push only while a credit is held, so the queue cannot overflow
    credit_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
        msi_valid_i |-> credits > 0)
        else begin
            $error("MSI pushed without a credit");
            fail_count++;
        end

    // Queue never returns more credits than it has entries
    credit_bound: assert property (@(posedge clk_i) disable iff (!rst_ni)
        credits <= `MSI_QUEUE_DEPTH)
        else begin
            $error("More credits returned than the queue holds");
            fail_count++;
        end

    status_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
        status_valid_o |=> !status_valid_o)
        else begin
            $error("Completion status held for more than one cycle");
            fail_count++;
        end

endmodule

bind mrif_top tb_mrif_chk chk_i (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .msi_valid_i    (msi_valid_i),
    .credit_o       (credit_o),
    .mem_req_o      (mem_req_o),
    .mem_rsp_i      (mem_rsp_i),
    .status_valid_o (status_valid_o)
);
